//--- mips_pkg.sv
package mips_pkg;

	localparam int WORD_W      = 32;  // Data and instruction width
	localparam int PC_W        = 7;   // Instruction memory word address
	localparam int REG_ADDR_W  = 5;   // Register number
	localparam int DMEM_ADDR_W = 5;   // Data memory word address
	localparam int ALU_FN_W    = 4;
	localparam int FWD_W       = 2;
	localparam int NUM_REGS    = 32;
	localparam int IMEM_DEPTH  = 128;
	localparam int DMEM_DEPTH  = 32;

	typedef logic [WORD_W-1:0]      word_t;
	typedef logic [PC_W-1:0]        pc_t;
	typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
	typedef logic [DMEM_ADDR_W-1:0] dmem_addr_t;
	typedef logic [ALU_FN_W-1:0]    alu_fn_t;
	typedef logic [FWD_W-1:0]       fwd_sel_t;
	typedef word_t [NUM_REGS-1:0]   regs_t;  // Register file image, 1024 bits

	// Primary opcodes, instr[31:26]
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_ANDI  = 6'h0c;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	// R-type funct field, instr[5:0]
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	// ALU function codes
	localparam alu_fn_t ALU_AND = 4'b0000;
	localparam alu_fn_t ALU_OR  = 4'b0001;
	localparam alu_fn_t ALU_ADD = 4'b0010;
	localparam alu_fn_t ALU_SUB = 4'b0110;
	localparam alu_fn_t ALU_SLT = 4'b0111;

	// Forwarding sources seen by decode
	localparam fwd_sel_t FWD_REG = 2'd0;
	localparam fwd_sel_t FWD_EX  = 2'd1;
	localparam fwd_sel_t FWD_MEM = 2'd2;
	localparam fwd_sel_t FWD_WB  = 2'd3;

	localparam word_t NOP_WORD = '0;

	typedef struct packed {
		alu_fn_t alu_fn;
		logic    reg_dst;     // 1 selects rd as destination
		logic    alu_src;     // 1 selects immediate as operand B
		logic    mem_write;
		logic    reg_write;
		logic    mem_to_reg;  // Set only for loads
	} ctrl_t;

	typedef struct packed {
		pc_t   next_pc;  // Address after this instruction
		word_t instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     data1;  // Forwarded rs value
		word_t     data2;  // Forwarded rt value
		word_t     imm;
		reg_addr_t rt;
		reg_addr_t rd;
	} id_ex_t;

	typedef struct packed {
		logic      mem_to_reg;
		logic      reg_write;
		logic      mem_write;
		word_t     alu_result;
		word_t     store_data;
		reg_addr_t dst;
	} ex_mem_t;

	typedef struct packed {
		logic      reg_write;
		logic      mem_to_reg;
		word_t     alu_result;
		word_t     load_data;
		reg_addr_t dst;
	} mem_wb_t;

endpackage

//--- fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage import mips_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   enable,
	input  logic   stall,
	input  logic   branch_taken,
	input  pc_t    branch_pc,
	input  logic   imem_we,
	input  pc_t    imem_addr,
	input  word_t  imem_data,
	output pc_t    pc,
	output word_t  instr,
	output if_id_t if_id
);

	word_t imem [IMEM_DEPTH];  // Program store
	pc_t   pc_inc;

	assign pc_inc = pc + 1'b1;  // Wraps at 128 words
	assign instr  = imem[pc];   // Asynchronous read

	// Load port, used before the run
	always_ff @(posedge clk) begin
		if (imem_we)
			imem[imem_addr] <= imem_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc    <= '0;
			if_id <= '0;
		end else if (enable && !stall) begin  // Hold on freeze or load-use
			if_id.next_pc <= pc_inc;
			if (branch_taken) begin
				pc          <= branch_pc;  // Redirect from decode
				if_id.instr <= NOP_WORD;   // Squash the wrong-path fetch
			end else begin
				pc          <= pc_inc;
				if_id.instr <= instr;
			end
		end
	end

endmodule

//--- hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit import mips_pkg::*; (
	input  if_id_t    if_id,
	input  id_ex_t    id_ex,
	input  reg_addr_t ex_dst,   // Destination chosen in EX
	input  ex_mem_t   ex_mem,
	input  mem_wb_t   mem_wb,
	output fwd_sel_t  fwd_a,
	output fwd_sel_t  fwd_b,
	output logic      stall
);

	reg_addr_t rs;
	reg_addr_t rt;
	logic      ex_valid;
	logic      mem_valid;
	logic      wb_valid;
	logic      load_in_ex;

	assign rs = if_id.instr[25:21];
	assign rt = if_id.instr[20:16];

	// A source counts only with its write on and a nonzero target
	assign ex_valid  = id_ex.ctrl.reg_write && (ex_dst != '0);
	assign mem_valid = ex_mem.reg_write && (ex_mem.dst != '0);
	assign wb_valid  = mem_wb.reg_write && (mem_wb.dst != '0);

	// Youngest producer wins
	function automatic fwd_sel_t pick_src(input reg_addr_t src);
		fwd_sel_t sel;
		sel = FWD_REG;
		if (src != '0) begin
			if (ex_valid && ex_dst == src)
				sel = FWD_EX;
			else if (mem_valid && ex_mem.dst == src)
				sel = FWD_MEM;
			else if (wb_valid && mem_wb.dst == src)
				sel = FWD_WB;
		end
		return sel;
	endfunction

	assign fwd_a = pick_src(rs);
	assign fwd_b = pick_src(rt);

	// Load data is not ready until MEM, so the consumer waits a cycle
	assign load_in_ex = id_ex.ctrl.mem_to_reg && (id_ex.rt != '0);
	assign stall      = load_in_ex && (id_ex.rt == rs || id_ex.rt == rt);

endmodule

//--- decode_stage.sv
`timescale 1ns/100ps

module decode_stage import mips_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     enable,
	input  logic     stall,
	input  if_id_t   if_id,
	input  fwd_sel_t fwd_a,
	input  fwd_sel_t fwd_b,
	input  word_t    ex_result,   // ALU output of the EX instruction
	input  word_t    mem_result,  // Result of the MEM instruction
	input  mem_wb_t  mem_wb,
	output id_ex_t   id_ex,
	output logic     branch_taken,
	output pc_t      branch_pc,
	output regs_t    registers
);

	regs_t     regs;
	word_t     wb_data;
	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	word_t     imm;
	ctrl_t     ctrl;
	word_t     op_a;
	word_t     op_b;
	logic      is_beq;
	logic      is_bne;

	assign opcode = if_id.instr[31:26];
	assign rs     = if_id.instr[25:21];
	assign rt     = if_id.instr[20:16];
	assign rd     = if_id.instr[15:11];
	assign funct  = if_id.instr[5:0];
	assign imm    = {{16{if_id.instr[15]}}, if_id.instr[15:0]};  // Sign extension

	assign wb_data   = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;
	assign registers = regs;

	// Register file, r0 never written
	always_ff @(posedge clk) begin
		if (reset)
			regs <= '0;
		else if (enable && mem_wb.reg_write && mem_wb.dst != '0)
			regs[mem_wb.dst] <= wb_data;
	end

	always_comb begin
		ctrl = '0;  // Unknown opcodes become no-ops
		case (opcode)
			OP_RTYPE: begin
				ctrl.reg_dst   = 1'b1;
				ctrl.reg_write = 1'b1;
				case (funct)
					FN_ADD:  ctrl.alu_fn = ALU_ADD;
					FN_SUB:  ctrl.alu_fn = ALU_SUB;
					FN_AND:  ctrl.alu_fn = ALU_AND;
					FN_OR:   ctrl.alu_fn = ALU_OR;
					FN_SLT:  ctrl.alu_fn = ALU_SLT;
					default: ctrl = '0;  // Also covers the all-zero NOP
				endcase
			end
			OP_ADDI: begin
				ctrl.alu_fn    = ALU_ADD;
				ctrl.alu_src   = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_ANDI: begin
				ctrl.alu_fn    = ALU_AND;
				ctrl.alu_src   = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_ORI: begin
				ctrl.alu_fn    = ALU_OR;
				ctrl.alu_src   = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_LW: begin
				ctrl.alu_fn     = ALU_ADD;  // Base plus offset
				ctrl.alu_src    = 1'b1;
				ctrl.reg_write  = 1'b1;
				ctrl.mem_to_reg = 1'b1;
			end
			OP_SW: begin
				ctrl.alu_fn    = ALU_ADD;
				ctrl.alu_src   = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			default: ctrl = '0;  // Branches write nothing either
		endcase
	end

	// Operand muxes fed by the hazard unit
	always_comb begin
		case (fwd_a)
			FWD_EX:  op_a = ex_result;
			FWD_MEM: op_a = mem_result;
			FWD_WB:  op_a = wb_data;
			default: op_a = regs[rs];
		endcase
		case (fwd_b)
			FWD_EX:  op_b = ex_result;
			FWD_MEM: op_b = mem_result;
			FWD_WB:  op_b = wb_data;
			default: op_b = regs[rt];
		endcase
	end

	// Branch resolved here, one bubble when taken
	assign is_beq       = (opcode == OP_BEQ);
	assign is_bne       = (opcode == OP_BNE);
	assign branch_taken = !stall &&
		((is_beq && op_a == op_b) || (is_bne && op_a != op_b));  // Stale operands on stall
	assign branch_pc    = if_id.next_pc + imm[PC_W-1:0];  // Offset relative to pc+1

	always_ff @(posedge clk) begin
		if (reset) begin
			id_ex <= '0;
		end else if (enable) begin
			if (stall) begin
				id_ex <= '0;  // Bubble
			end else begin
				id_ex.ctrl  <= ctrl;
				id_ex.data1 <= op_a;
				id_ex.data2 <= op_b;
				id_ex.imm   <= imm;
				id_ex.rt    <= rt;
				id_ex.rd    <= rd;
			end
		end
	end

endmodule

//--- execute_stage.sv
`timescale 1ns/100ps

module execute_stage import mips_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      enable,
	input  id_ex_t    id_ex,
	output word_t     ex_result,  // Back to decode for forwarding
	output reg_addr_t ex_dst,
	output ex_mem_t   ex_mem
);

	word_t alu_a;
	word_t alu_b;

	assign alu_a = id_ex.data1;
	assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : id_ex.data2;  // Immediate for I-type

	always_comb begin
		case (id_ex.ctrl.alu_fn)
			ALU_ADD: ex_result = alu_a + alu_b;
			ALU_SUB: ex_result = alu_a - alu_b;
			ALU_AND: ex_result = alu_a & alu_b;
			ALU_OR:  ex_result = alu_a | alu_b;
			ALU_SLT: ex_result = {31'd0, $signed(alu_a) < $signed(alu_b)};  // Signed compare
			default: ex_result = '0;
		endcase
	end

	// rd for R-type, rt for loads and immediates
	assign ex_dst = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_mem <= '0;
		end else if (enable) begin
			ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
			ex_mem.reg_write  <= id_ex.ctrl.reg_write;
			ex_mem.mem_write  <= id_ex.ctrl.mem_write;
			ex_mem.alu_result <= ex_result;
			ex_mem.store_data <= id_ex.data2;  // Already forwarded in decode
			ex_mem.dst        <= ex_dst;
		end
	end

endmodule

//--- mem_stage.sv
`timescale 1ns/100ps

module mem_stage import mips_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    enable,
	input  ex_mem_t ex_mem,
	output word_t   mem_result,  // To decode for forwarding
	output mem_wb_t mem_wb
);

	word_t      dmem [DMEM_DEPTH];
	dmem_addr_t addr;
	word_t      load_data;

	assign addr      = ex_mem.alu_result[DMEM_ADDR_W-1:0];  // Word addressed
	assign load_data = dmem[addr];

	always_ff @(posedge clk) begin
		if (enable && ex_mem.mem_write)
			dmem[addr] <= ex_mem.store_data;
	end

	assign mem_result = ex_mem.mem_to_reg ? load_data : ex_mem.alu_result;

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_wb <= '0;
		end else if (enable) begin
			mem_wb.reg_write  <= ex_mem.reg_write;
			mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
			mem_wb.alu_result <= ex_mem.alu_result;
			mem_wb.load_data  <= load_data;
			mem_wb.dst        <= ex_mem.dst;
		end
	end

endmodule

//--- pipeline.sv
`timescale 1ns/100ps

module pipeline import mips_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    enable,     // Low freezes everything
	input  logic    imem_we,
	input  pc_t     imem_addr,
	input  word_t   imem_data,
	output word_t   instr,      // Word at current pc
	output pc_t     pc,
	output if_id_t  if_id,
	output id_ex_t  id_ex,
	output ex_mem_t ex_mem,
	output mem_wb_t mem_wb,
	output regs_t   registers
);

	logic      stall;
	logic      branch_taken;
	pc_t       branch_pc;
	fwd_sel_t  fwd_a;
	fwd_sel_t  fwd_b;
	word_t     ex_result;
	reg_addr_t ex_dst;
	word_t     mem_result;

	fetch_stage u_fetch (
		.clk          (clk),
		.reset        (reset),
		.enable       (enable),
		.stall        (stall),
		.branch_taken (branch_taken),
		.branch_pc    (branch_pc),
		.imem_we      (imem_we),
		.imem_addr    (imem_addr),
		.imem_data    (imem_data),
		.pc           (pc),
		.instr        (instr),
		.if_id        (if_id)
	);

	hazard_unit u_hazard (
		.if_id  (if_id),
		.id_ex  (id_ex),
		.ex_dst (ex_dst),
		.ex_mem (ex_mem),
		.mem_wb (mem_wb),
		.fwd_a  (fwd_a),
		.fwd_b  (fwd_b),
		.stall  (stall)
	);

	decode_stage u_decode (
		.clk          (clk),
		.reset        (reset),
		.enable       (enable),
		.stall        (stall),
		.if_id        (if_id),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b),
		.ex_result    (ex_result),
		.mem_result   (mem_result),
		.mem_wb       (mem_wb),
		.id_ex        (id_ex),
		.branch_taken (branch_taken),
		.branch_pc    (branch_pc),
		.registers    (registers)
	);

	execute_stage u_execute (
		.clk       (clk),
		.reset     (reset),
		.enable    (enable),
		.id_ex     (id_ex),
		.ex_result (ex_result),
		.ex_dst    (ex_dst),
		.ex_mem    (ex_mem)
	);

	mem_stage u_mem (
		.clk        (clk),
		.reset      (reset),
		.enable     (enable),
		.ex_mem     (ex_mem),
		.mem_result (mem_result),
		.mem_wb     (mem_wb)
	);

endmodule

//--- pipeline_chk.sv
`timescale 1ns/100ps

module pipeline_chk import mips_pkg::*; (
	input logic   clk,
	input logic   reset,
	input logic   enable,
	input logic   stall,
	input logic   branch_taken,
	input pc_t    pc,
	input if_id_t if_id,
	input id_ex_t id_ex,
	input regs_t  registers
);

	int fail_count = 0;  // Failure tally for the end-of-run summary

	a_reset_ctrl: assert property (@(posedge clk) reset |=> id_ex.ctrl == '0)
		else begin
			$error("id_ex control bits not cleared by reset");
			fail_count++;
		end

	a_pc_hold: assert property (@(posedge clk) (!reset && (!enable || stall)) |=> $stable(pc))
		else begin
			$error("pc moved while frozen or stalled");
			fail_count++;
		end

	a_r0_zero: assert property (@(posedge clk) !reset |-> registers[0] == '0)
		else begin
			$error("register 0 is not zero");
			fail_count++;
		end

	// Wrong-path fetch squashed
	a_branch_flush: assert property (@(posedge clk)
			(!reset && enable && branch_taken) |=> if_id.instr == '0)
		else begin
			$error("if_id not flushed after taken branch");
			fail_count++;
		end

endmodule

bind pipeline pipeline_chk u_chk (
	.clk          (clk),
	.reset        (reset),
	.enable       (enable),
	.stall        (stall),
	.branch_taken (branch_taken),
	.pc           (pc),
	.if_id        (if_id),
	.id_ex        (id_ex),
	.registers    (registers)
);

//--- tb_pipeline.sv
`timescale 1ns/100ps

module tb_pipeline import mips_pkg::*; ();

	localparam int  PROG_LEN     = 22;
	localparam pc_t HALT_PC      = 7'd20;         // Self-branch address
	localparam int  RESET_CYCLES = 4;
	localparam int  PAUSE_AT     = 12;            // Cycle after reset release
	localparam int  PAUSE_LEN    = 10;
	localparam int  HALT_HOLD    = 8;
	localparam int  CYCLE_LIMIT  = 3 * PROG_LEN + 60;
	localparam int  NUM_EXP      = 16;

	typedef struct packed {
		reg_addr_t r;  // Register number
		word_t     v;  // Expected value at halt
	} reg_exp_t;

	logic    clk;
	logic    reset;
	logic    enable;
	logic    imem_we;
	pc_t     imem_addr;
	word_t   imem_data;
	word_t   instr;
	pc_t     pc;
	if_id_t  if_id;
	id_ex_t  id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;
	regs_t   registers;

	word_t    prog [PROG_LEN];
	reg_exp_t exp_tab [NUM_EXP];
	word_t    rng_state;
	int       word_errors;
	int       pc_errors;
	int       stage_errors;
	int       cycles;       // Counts from reset release
	regs_t    pause_regs;   // Register image at the pause edge
	if_id_t   exp_if_id;    // Pipeline contents at the pause edge
	id_ex_t   exp_id_ex;
	ex_mem_t  exp_ex_mem;
	mem_wb_t  exp_mem_wb;
	pc_t      last_pc;

	pipeline DUT (
		.clk       (clk),
		.reset     (reset),
		.enable    (enable),
		.imem_we   (imem_we),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.instr     (instr),
		.pc        (pc),
		.if_id     (if_id),
		.id_ex     (id_ex),
		.ex_mem    (ex_mem),
		.mem_wb    (mem_wb),
		.registers (registers)
	);

	always #5 clk = ~clk;  // 10 ns period

	function automatic word_t lcg_next(input word_t s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic word_t sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic word_t r_instr(input logic [5:0] fn, input reg_addr_t rd, rs, rt);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t i_instr(input logic [5:0] op, input reg_addr_t rt, rs,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			word_errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_pc(input pc_t got, input pc_t exp, input string what);
		if (got !== exp) begin
			pc_errors++;
			$display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_if_id(input if_id_t got, input if_id_t exp, input string what);
		if (got !== exp) begin
			stage_errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_id_ex(input id_ex_t got, input id_ex_t exp, input string what);
		if (got !== exp) begin
			stage_errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_ex_mem(input ex_mem_t got, input ex_mem_t exp, input string what);
		if (got !== exp) begin
			stage_errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_mem_wb(input mem_wb_t got, input mem_wb_t exp, input string what);
		mem_wb_t masked;
		masked = got;
		if (!exp.mem_to_reg)
			masked.load_data = exp.load_data;  // Load data only matters for loads
		if (masked !== exp) begin
			stage_errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_stages(input string when);
		check_if_id(if_id, exp_if_id, $sformatf("if_id %s", when));
		check_id_ex(id_ex, exp_id_ex, $sformatf("id_ex %s", when));
		check_ex_mem(ex_mem, exp_ex_mem, $sformatf("ex_mem %s", when));
		check_mem_wb(mem_wb, exp_mem_wb, $sformatf("mem_wb %s", when));
	endtask

	// Program words and register results at halt
	task automatic build_tables();
		word_t a;
		word_t b;
		word_t r [NUM_EXP];
		rng_state = lcg_next(rng_state);
		a         = sext16(rng_state[31:16]);
		rng_state = lcg_next(rng_state);
		b         = sext16(rng_state[31:16]);
		prog[0]  = i_instr(OP_ADDI, 5'd1, 5'd0, a[15:0]);
		prog[1]  = i_instr(OP_ADDI, 5'd2, 5'd0, b[15:0]);
		prog[2]  = r_instr(FN_ADD, 5'd3, 5'd1, 5'd2);      // r1 from MEM, r2 from EX
		prog[3]  = r_instr(FN_SUB, 5'd4, 5'd3, 5'd1);      // r1 from WB
		prog[4]  = r_instr(FN_AND, 5'd5, 5'd4, 5'd3);
		prog[5]  = r_instr(FN_OR, 5'd6, 5'd5, 5'd1);
		prog[6]  = r_instr(FN_SLT, 5'd7, 5'd1, 5'd2);
		prog[7]  = i_instr(OP_ANDI, 5'd8, 5'd6, 16'h0ff0);
		prog[8]  = i_instr(OP_ORI, 5'd9, 5'd8, 16'h1234);
		prog[9]  = i_instr(OP_SW, 5'd3, 5'd0, 16'd4);
		prog[10] = i_instr(OP_LW, 5'd10, 5'd0, 16'd4);
		prog[11] = r_instr(FN_ADD, 5'd11, 5'd10, 5'd1);    // Load-use stall
		prog[12] = i_instr(OP_BEQ, 5'd3, 5'd10, 16'd1);    // Taken
		prog[13] = i_instr(OP_ADDI, 5'd12, 5'd0, 16'h55);  // Skipped
		prog[14] = i_instr(OP_BNE, 5'd1, 5'd1, 16'd1);     // Falls through
		prog[15] = i_instr(OP_ADDI, 5'd13, 5'd0, 16'h66);
		prog[16] = i_instr(OP_BNE, 5'd0, 5'd13, 16'd1);    // Taken
		prog[17] = i_instr(OP_ADDI, 5'd14, 5'd0, 16'h77);  // Skipped
		prog[18] = i_instr(OP_BEQ, 5'd0, 5'd13, 16'd1);    // Falls through
		prog[19] = i_instr(OP_ADDI, 5'd15, 5'd13, 16'd1);
		prog[20] = i_instr(OP_BEQ, 5'd0, 5'd0, 16'hffff);  // Halt loop
		prog[21] = NOP_WORD;  // Fetched in the halt loop but always squashed
		r[0]  = '0;
		r[1]  = a;
		r[2]  = b;
		r[3]  = r[1] + r[2];
		r[4]  = r[3] - r[1];
		r[5]  = r[4] & r[3];
		r[6]  = r[5] | r[1];
		r[7]  = ($signed(r[1]) < $signed(r[2])) ? 32'd1 : 32'd0;
		r[8]  = r[6] & 32'h0000_0ff0;
		r[9]  = r[8] | 32'h0000_1234;
		r[10] = r[3];          // Round trip through word 4
		r[11] = r[10] + r[1];
		r[12] = '0;
		r[13] = 32'h66;
		r[14] = '0;
		r[15] = r[13] + 32'd1;
		for (int i = 0; i < NUM_EXP; i++) begin
			exp_tab[i].r = reg_addr_t'(i);
			exp_tab[i].v = r[i];
		end
		pause_regs = '0;
		for (int i = 1; i <= 8; i++)
			pause_regs[i] = r[i];  // Writes up to the andi have retired
		// No stall or branch yet, so add, lw, sw and ori sit in IF/ID to MEM/WB
		exp_if_id.next_pc          = pc_t'(PAUSE_AT);
		exp_if_id.instr            = prog[PAUSE_AT - 1];
		exp_id_ex                  = '0;
		exp_id_ex.ctrl.alu_fn      = ALU_ADD;
		exp_id_ex.ctrl.alu_src     = 1'b1;
		exp_id_ex.ctrl.reg_write   = 1'b1;
		exp_id_ex.ctrl.mem_to_reg  = 1'b1;
		exp_id_ex.imm              = 32'd4;
		exp_id_ex.rt               = 5'd10;  // r10 still zero, so data2 is zero
		exp_ex_mem                 = '0;
		exp_ex_mem.mem_write       = 1'b1;
		exp_ex_mem.alu_result      = 32'd4;
		exp_ex_mem.store_data      = r[3];
		exp_ex_mem.dst             = 5'd3;
		exp_mem_wb                 = '0;
		exp_mem_wb.reg_write       = 1'b1;
		exp_mem_wb.alu_result      = r[9];
		exp_mem_wb.dst             = 5'd9;
	endtask

	initial begin
		int cyc;
		int hold;
		clk          = 1'b0;
		reset        = 1'b1;
		enable       = 1'b1;
		imem_we      = 1'b0;
		imem_addr    = '0;
		imem_data    = '0;
		rng_state    = 32'd1;  // Seed
		word_errors  = 0;
		pc_errors    = 0;
		stage_errors = 0;
		build_tables();
		for (int i = 0; i < PROG_LEN; i++) begin  // Load under reset
			@(posedge clk);
			#1;
			imem_we   = 1'b1;
			imem_addr = pc_t'(i);
			imem_data = prog[i];
		end
		@(posedge clk);
		#1;
		imem_we = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		check_pc(pc, '0, "pc after reset");
		for (int r = 0; r < NUM_REGS; r++)
			check_word(registers[r], '0, $sformatf("r%0d after reset", r));
		reset   = 1'b0;
		cyc     = 0;
		hold    = 0;
		last_pc = '0;
		// Self-branch alternates pc between halt and halt+1
		while (hold < HALT_HOLD) begin
			@(posedge clk);
			#1;
			cyc++;
			if (pc < PROG_LEN)
				check_word(instr, prog[pc], $sformatf("instr at pc %0d", pc));
			// Pause edge and the frozen cycles after it
			if (cyc >= PAUSE_AT && cyc <= PAUSE_AT + PAUSE_LEN) begin
				check_pc(pc, pc_t'(PAUSE_AT), "pc during pause");
				for (int r = 0; r < NUM_REGS; r++)
					check_word(registers[r], pause_regs[r], $sformatf("r%0d during pause", r));
				check_stages("during pause");
			end
			if (cyc == PAUSE_AT)
				enable = 1'b0;  // Freeze for PAUSE_LEN edges
			else if (cyc == PAUSE_AT + PAUSE_LEN)
				enable = 1'b1;
			if (enable && (pc == HALT_PC || pc == pc_t'(HALT_PC + 1)))
				hold++;
			else
				hold = 0;
			last_pc = pc;
		end
		@(posedge clk);
		#1;
		check_pc(pc, (last_pc == HALT_PC) ? pc_t'(HALT_PC + 1) : HALT_PC, "pc in halt loop");
		for (int i = 0; i < NUM_EXP; i++)
			check_word(registers[exp_tab[i].r], exp_tab[i].v, $sformatf("r%0d", exp_tab[i].r));
		$display("Summary: %0d word, %0d pc, %0d stage errors, %0d assertion failures",
			word_errors, pc_errors, stage_errors, DUT.u_chk.fail_count);
		if (word_errors + pc_errors + stage_errors + DUT.u_chk.fail_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// Run limit scaled to program length
	always @(posedge clk) begin
		if (reset) begin
			cycles <= 0;
		end else begin
			cycles <= cycles + 1;
			if (cycles >= CYCLE_LIMIT) begin
				$display("Timeout: program never reached its halt address in %0d cycles",
					CYCLE_LIMIT);
				$display("Summary: %0d word, %0d pc, %0d stage errors, %0d assertion failures",
					word_errors, pc_errors, stage_errors, DUT.u_chk.fail_count);
				$display("Testbench failed");
				$finish;
			end
		end
	end

endmodule

//--- all.f
mips_pkg.sv
fetch_stage.sv
hazard_unit.sv
decode_stage.sv
execute_stage.sv
mem_stage.sv
pipeline.sv
pipeline_chk.sv
tb_pipeline.sv
